// File: design/s18_consts.svh
`ifndef S18_CONSTS_SVH
`define S18_CONSTS_SVH

// Mapper regions in the one-hot active word
`define S18_REG_RAM   3
`define S18_REG_ORAM  4
`define S18_REG_VRAM  5
`define S18_REG_PAL   6
`define S18_REG_IO    7

// Board variant bits in game_id
`define S18_PCB_5874          0
`define S18_PCB_5987_DESERTBR 1
`define S18_PCB_5987          2
`define S18_PCB_7525          3
`define S18_PCB_5873          4
`define S18_PCB_7248          5

// I/O area locations
`define S18_GUN_PAGE  12'h301
`define S18_PRIO_A13  1'b1
`define S18_PRIO_A12  1'b0

`define S18_DW        16

`endif

// File: design/s18_pkg.sv
`include "s18_consts.svh"

package s18_pkg;

    // One 68000 bus cycle, strobes active low
    typedef struct packed {
        logic [23:1]         addr;
        logic                rnw;
        logic                asn;
        logic                udsn;
        logic                ldsn;
        logic [`S18_DW-1:0]  wdata;
    } bus_req_t;

    typedef struct packed {
        logic rom;
        logic chr;
        logic objram;
        logic pal;
        logic io;
        logic vdp;
        logic vram;
        logic ram;
        logic bank;
    } cs_t;

    // Read data offered by each memory or device
    typedef struct packed {
        logic [`S18_DW-1:0] ram;
        logic [`S18_DW-1:0] vram;
        logic [`S18_DW-1:0] rom;
        logic [`S18_DW-1:0] chr;
        logic [`S18_DW-1:0] pal;
        logic [`S18_DW-1:0] obj;
        logic [`S18_DW-1:0] vdp;
    } rd_src_t;

    typedef struct packed {
        logic [8:0] p1_x;
        logic [8:0] p1_y;
        logic [8:0] p2_x;
        logic [8:0] p2_y;
    } gun_pos_t;

endpackage

// File: design/s18_region_decode.sv
`timescale 1ns/1ps
`include "s18_consts.svh"

module s18_region_decode (
    input  logic               clk,
    input  logic               rst,
    input  s18_pkg::bus_req_t  bus_i,
    input  logic [7:0]         active_i,
    input  logic [7:0]         game_id_i,
    output s18_pkg::cs_t       cs_o,
    output logic [20:1]        rom_addr_o
);

    logic         ds_low;
    logic         access;
    logic         banked_pcb;
    s18_pkg::cs_t cs_next;

    assign ds_low = !bus_i.udsn || !bus_i.ldsn;
    // Reads may start on AS before the data strobes fall
    assign access = ds_low || (!bus_i.asn && bus_i.rnw);

    assign banked_pcb = game_id_i[`S18_PCB_7525] | game_id_i[`S18_PCB_5987]
                      | game_id_i[`S18_PCB_5987_DESERTBR];

    always_comb begin
        cs_next.rom    = (active_i[0] || (active_i[1] && !game_id_i[`S18_PCB_7248]))
                         && bus_i.rnw;
        // Shadow Dancer moves the VDP down to region 1
        cs_next.vdp    = game_id_i[`S18_PCB_7248] ? active_i[1] : active_i[2];
        cs_next.chr    = active_i[`S18_REG_VRAM] && bus_i.addr[16];
        cs_next.vram   = ds_low && active_i[`S18_REG_VRAM] && !bus_i.addr[16];
        cs_next.ram    = ds_low && active_i[`S18_REG_RAM];
        cs_next.objram = active_i[`S18_REG_ORAM];
        cs_next.pal    = active_i[`S18_REG_PAL];
        cs_next.io     = active_i[`S18_REG_IO];
        cs_next.bank   = banked_pcb && active_i[1] && !bus_i.rnw;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cs_o <= '0;
        end else if (access) begin
            cs_o <= cs_next;
        end else begin
            cs_o <= '0;
        end
    end

    // Banked program ROM address
    always_comb begin
        rom_addr_o = bus_i.addr[20:1];
        if (active_i[0]) begin
            if (game_id_i[`S18_PCB_5874] | game_id_i[`S18_PCB_7248]) begin
                rom_addr_o[20:19] = 2'b00;
            end
            if (banked_pcb) begin
                rom_addr_o[20] = 1'b0;
            end
        end
        // Region 1 points past the fixed ROM half
        if (active_i[1]) begin
            if (game_id_i[`S18_PCB_7525] | game_id_i[`S18_PCB_5873]
                    | game_id_i[`S18_PCB_5987]) begin
                rom_addr_o[20:19] = {1'b0, bus_i.addr[21]};
            end
            if (game_id_i[`S18_PCB_5987_DESERTBR]) begin
                rom_addr_o[20] = bus_i.addr[21];
            end
        end
    end

endmodule

// File: design/s18_gun_adc.sv
`timescale 1ns/1ps
`include "s18_consts.svh"

module s18_gun_adc (
    input  logic               clk,
    input  logic               rst,
    input  logic               io_we_i,
    input  logic               io_rd_i,
    input  logic [15:1]        addr_i,
    input  s18_pkg::gun_pos_t  gun_i,
    output logic               bit_o
);

    logic [7:0] shift_q;
    logic       io_rd_q;
    logic       in_page;
    logic       rd_start;

    // Maps 0-319 onto roughly 0-255
    function automatic logic [7:0] xscale(input logic [8:0] x);
        logic [15:0] xw;
        logic [15:0] s;
        logic [15:0] factor;
        logic [15:0] mult;
        xw     = {7'd0, x};
        s      = (xw >> 3) + (xw >> 4) + (xw >> 5);
        factor = (x < 9'd160) ? 16'd204 + s : 16'd274 - s;
        mult   = xw * factor;
        return mult[15:8];
    endfunction

    assign in_page  = addr_i[15:4] == `S18_GUN_PAGE;
    assign rd_start = io_rd_i && !io_rd_q && in_page;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            io_rd_q <= 1'b0;
            bit_o   <= 1'b0;
        end else begin
            io_rd_q <= io_rd_i;
            if (rd_start) begin
                bit_o <= shift_q[7];
            end
        end
    end

    // Channel latch on write, serial shift on each new read
    always_ff @(posedge clk) begin
        if (io_we_i && in_page) begin
            case (addr_i[2:1])
                2'd0:    shift_q <= ~gun_i.p1_y[7:0];
                2'd1:    shift_q <= xscale(gun_i.p1_x);
                2'd2:    shift_q <= ~gun_i.p2_y[7:0];
                default: shift_q <= xscale(gun_i.p2_x);
            endcase
        end else if (rd_start) begin
            shift_q <= {shift_q[6:0], 1'b0};
        end
    end

endmodule

// File: design/s18_io_area.sv
`timescale 1ns/1ps
`include "s18_consts.svh"

module s18_io_area (
    input  logic               clk,
    input  logic               rst,
    input  s18_pkg::cs_t       cs_i,
    input  s18_pkg::bus_req_t  bus_i,
    input  s18_pkg::gun_pos_t  gun_i,
    output logic [2:0]         vdp_prio_o,
    output logic [7:0]         io_byte_o
);

    logic io_we;
    logic io_rd;
    logic gun_bit;

    // Only the low byte lane reaches the I/O chips
    assign io_we = cs_i.io && !bus_i.rnw && !bus_i.ldsn;
    assign io_rd = cs_i.io &&  bus_i.rnw && !bus_i.ldsn;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            vdp_prio_o <= 3'd0;
        end else if (io_we && bus_i.addr[13] == `S18_PRIO_A13
                           && bus_i.addr[12] == `S18_PRIO_A12) begin
            vdp_prio_o <= bus_i.wdata[2:0];
        end
    end

    s18_gun_adc u_gun_adc (
        .clk     ( clk               ),
        .rst     ( rst               ),
        .io_we_i ( io_we             ),
        .io_rd_i ( io_rd             ),
        .addr_i  ( bus_i.addr[15:1]  ),
        .gun_i   ( gun_i             ),
        .bit_o   ( gun_bit           )
    );

    // Rest of the I/O area floats high
    assign io_byte_o = (bus_i.addr[15:4] == `S18_GUN_PAGE) ? {gun_bit, 7'h7f} : 8'hff;

endmodule

// File: design/s18_read_mux.sv
`timescale 1ns/1ps
`include "s18_consts.svh"

module s18_read_mux (
    input  logic                clk,
    input  logic                rst,
    input  s18_pkg::cs_t        cs_i,
    input  s18_pkg::rd_src_t    rdata_i,
    input  logic [7:0]          io_byte_i,
    input  logic                none_i,
    input  logic [`S18_DW-1:0]  mapper_data_i,
    output logic [`S18_DW-1:0]  rd_data_o
);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rd_data_o <= '0;
        end else if (cs_i.ram) begin
            rd_data_o <= rdata_i.ram;
        end else if (cs_i.vram) begin
            rd_data_o <= rdata_i.vram;
        end else if (cs_i.rom) begin
            rd_data_o <= rdata_i.rom;
        end else if (cs_i.chr) begin
            rd_data_o <= rdata_i.chr;
        end else if (cs_i.pal) begin
            rd_data_o <= rdata_i.pal;
        end else if (cs_i.objram) begin
            rd_data_o <= rdata_i.obj;
        end else if (cs_i.io) begin
            // I/O sits on the low byte only
            rd_data_o <= {8'hff, io_byte_i};
        end else if (cs_i.vdp) begin
            rd_data_o <= rdata_i.vdp;
        end else if (none_i) begin
            rd_data_o <= mapper_data_i;
        end else begin
            rd_data_o <= '1;
        end
    end

endmodule

// File: design/s18_main_bus.sv
`timescale 1ns/1ps
`include "s18_consts.svh"

module s18_main_bus (
    input  logic                clk,
    input  logic                rst,
    input  s18_pkg::bus_req_t   bus_i,
    input  logic [7:0]          active_i,
    input  logic [7:0]          game_id_i,
    input  logic                none_i,
    input  logic [`S18_DW-1:0]  mapper_data_i,
    input  s18_pkg::rd_src_t    rdata_i,
    input  s18_pkg::gun_pos_t   gun_i,
    output s18_pkg::cs_t        cs_o,
    output logic [20:1]         rom_addr_o,
    output logic [2:0]          vdp_prio_o,
    output logic [`S18_DW-1:0]  rd_data_o
);

    logic [7:0] io_byte;

    s18_region_decode u_decode (
        .clk        ( clk         ),
        .rst        ( rst         ),
        .bus_i      ( bus_i       ),
        .active_i   ( active_i    ),
        .game_id_i  ( game_id_i   ),
        .cs_o       ( cs_o        ),
        .rom_addr_o ( rom_addr_o  )
    );

    s18_io_area u_io_area (
        .clk        ( clk         ),
        .rst        ( rst         ),
        .cs_i       ( cs_o        ),
        .bus_i      ( bus_i       ),
        .gun_i      ( gun_i       ),
        .vdp_prio_o ( vdp_prio_o  ),
        .io_byte_o  ( io_byte     )
    );

    // CPU data input, one cycle behind the selects
    s18_read_mux u_read_mux (
        .clk           ( clk           ),
        .rst           ( rst           ),
        .cs_i          ( cs_o          ),
        .rdata_i       ( rdata_i       ),
        .io_byte_i     ( io_byte       ),
        .none_i        ( none_i        ),
        .mapper_data_i ( mapper_data_i ),
        .rd_data_o     ( rd_data_o     )
    );

endmodule

// File: verification/s18_assertions.sv
`timescale 1ns/1ps

module s18_assertions (
    input  logic               clk,
    input  logic               rst,
    input  s18_pkg::bus_req_t  bus_i,
    input  s18_pkg::cs_t       cs_i
);

    logic strobed;
    int   err_cnt;

    assign strobed = !bus_i.udsn || !bus_i.ldsn || (!bus_i.asn && bus_i.rnw);

    initial begin
        err_cnt = 0;
    end

    // Selects drop one cycle after the strobes go away
    idle_clears: assert property (@(posedge clk) disable iff (rst) !strobed |=> cs_i == '0)
        else begin
            $error("chip select still high after a cycle with no strobe");
            err_cnt = err_cnt + 1;
        end

    no_rom_write: assert property (@(posedge clk) disable iff (rst) !bus_i.rnw |=> !cs_i.rom)
        else begin
            $error("ROM selected on a write cycle");
            err_cnt = err_cnt + 1;
        end

    char_vram_apart: assert property (@(posedge clk) disable iff (rst) !(cs_i.chr && cs_i.vram))
        else begin
            $error("character RAM and tile RAM selected together");
            err_cnt = err_cnt + 1;
        end

endmodule

// File: verification/s18_checker.sv
`timescale 1ns/1ps
`include "s18_consts.svh"

module s18_checker (
    input  logic                clk,
    input  logic                check_i,
    input  logic [95:0]         name_i,
    input  logic [8:0]          exp_cs_i,
    input  logic [20:1]         exp_rom_i,
    input  logic [`S18_DW-1:0]  exp_rd_i,
    input  logic [2:0]          exp_prio_i,
    input  s18_pkg::cs_t        cs_i,
    input  logic [20:1]         rom_addr_i,
    input  logic [`S18_DW-1:0]  rd_data_i,
    input  logic [2:0]          vdp_prio_i,
    output int                  pass_cnt_o,
    output int                  fail_cnt_o
);

    logic [8:0] cs_bits;

    assign cs_bits = cs_i;

    initial begin
        pass_cnt_o = 0;
        fail_cnt_o = 0;
    end

    // Outputs still reflect the held access when the check strobe is seen
    always @(posedge clk) begin
        if (check_i) begin
            if (cs_bits === exp_cs_i && rom_addr_i === exp_rom_i
                    && rd_data_i === exp_rd_i && vdp_prio_i === exp_prio_i) begin
                pass_cnt_o = pass_cnt_o + 1;
                $display("Pass %0s", name_i);
            end else begin
                fail_cnt_o = fail_cnt_o + 1;
                $display("Fail %0s: expected cs=%h rom=%h rd=%h prio=%0d, actual cs=%h rom=%h rd=%h prio=%0d",
                         name_i, exp_cs_i, exp_rom_i, exp_rd_i, exp_prio_i,
                         cs_bits, rom_addr_i, rd_data_i, vdp_prio_i);
            end
        end
    end

endmodule

// File: verification/s18_tb.sv
`timescale 1ns/1ps
`include "s18_consts.svh"

module s18_tb;

    typedef struct packed {
        logic [95:0]        name;
        s18_pkg::bus_req_t  bus;
        logic [7:0]         active;
        logic [7:0]         game;
        logic               none;
        s18_pkg::gun_pos_t  gun;
        logic [8:0]         cs;
        logic [20:1]        rom;
        logic [`S18_DW-1:0] rd;
        logic [2:0]         prio;
    } row_t;

    // Chip-select patterns in cs_t bit order
    localparam logic [8:0] CS_ROM  = 9'h100;
    localparam logic [8:0] CS_CHR  = 9'h080;
    localparam logic [8:0] CS_OBJ  = 9'h040;
    localparam logic [8:0] CS_PAL  = 9'h020;
    localparam logic [8:0] CS_IO   = 9'h010;
    localparam logic [8:0] CS_VDP  = 9'h008;
    localparam logic [8:0] CS_VRAM = 9'h004;
    localparam logic [8:0] CS_RAM  = 9'h002;
    localparam logic [8:0] CS_BANK = 9'h001;

    logic clk;
    logic rst;
    s18_pkg::bus_req_t  bus;
    logic [7:0]         active;
    logic [7:0]         game_id;
    logic               none;
    logic [`S18_DW-1:0] mapper_data;
    s18_pkg::rd_src_t   rdata;
    s18_pkg::gun_pos_t  gun;
    s18_pkg::cs_t       cs;
    logic [20:1]        rom_addr;
    logic [2:0]         vdp_prio;
    logic [`S18_DW-1:0] rd_data;
    logic               check;
    row_t               cur;
    row_t               rows[$];
    logic [7:0]         game_now;
    logic [2:0]         prio_now;
    s18_pkg::gun_pos_t  gun_now;
    int                 pass_cnt;
    int                 fail_cnt;
    int                 cycles;
    int                 limit;

    s18_main_bus UUT (
        .clk(clk), .rst(rst), .bus_i(bus), .active_i(active), .game_id_i(game_id),
        .none_i(none), .mapper_data_i(mapper_data), .rdata_i(rdata), .gun_i(gun),
        .cs_o(cs), .rom_addr_o(rom_addr), .vdp_prio_o(vdp_prio), .rd_data_o(rd_data)
    );

    s18_checker u_checker (
        .clk(clk), .check_i(check), .name_i(cur.name), .exp_cs_i(cur.cs),
        .exp_rom_i(cur.rom), .exp_rd_i(cur.rd), .exp_prio_i(cur.prio), .cs_i(cs),
        .rom_addr_i(rom_addr), .rd_data_i(rd_data), .vdp_prio_i(vdp_prio),
        .pass_cnt_o(pass_cnt), .fail_cnt_o(fail_cnt)
    );

    bind s18_region_decode s18_assertions u_assertions (
        .clk(clk), .rst(rst), .bus_i(bus_i), .cs_i(cs_o)
    );

    task automatic add_row(input logic [95:0] name, input logic [23:0] addr, input logic rnw,
                           input logic [15:0] wdata, input logic [7:0] act, input logic nsel,
                           input logic [8:0] exp_cs, input logic [20:1] exp_rom,
                           input logic [15:0] exp_rd);
        row_t r;
        r.name = name;
        r.bus.addr = addr[23:1];
        r.bus.rnw = rnw;
        r.bus.asn = 1'b0;
        r.bus.udsn = 1'b0;
        r.bus.ldsn = 1'b0;
        r.bus.wdata = wdata;
        r.active = act;
        r.game = game_now;
        r.none = nsel;
        r.gun = gun_now;
        r.cs = exp_cs;
        r.rom = exp_rom;
        r.rd = exp_rd;
        r.prio = prio_now;
        rows.push_back(r);
    endtask

    // Serial ADC bits come out MSB first, one per read
    task automatic add_gun_reads(input logic [7:0] value, input int count);
        for (int i = 0; i < count; i++) begin
            add_row("gun_rd", 24'h003012, 1'b1, 16'h0000, 8'h80, 1'b0, CS_IO, 20'h01809,
                    {8'hff, value[7 - i], 7'h7f});
        end
    endtask

    task automatic release_bus();
        bus = '0;
        bus.rnw = 1'b1;
        bus.asn = 1'b1;
        bus.udsn = 1'b1;
        bus.ldsn = 1'b1;
        active = 8'h00;
        none = 1'b0;
    endtask

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        check = 1'b0;
        cur = '0;
        game_id = 8'h00;
        mapper_data = 16'ha5a5;
        rdata = {16'h1111, 16'h2222, 16'h3333, 16'h4444, 16'h5555, 16'h6666, 16'h7777};
        gun = '0;
        release_bus();
        game_now = 8'h01;
        prio_now = 3'd0;
        gun_now = '0;
        add_row("ram_rd", 24'h000100, 1'b1, 16'h0000, 8'h08, 1'b0, CS_RAM, 20'h00080, 16'h1111);
        add_row("objram_rd", 24'h000100, 1'b1, 16'h0000, 8'h10, 1'b0, CS_OBJ, 20'h00080, 16'h6666);
        add_row("vram_rd", 24'h000100, 1'b1, 16'h0000, 8'h20, 1'b0, CS_VRAM, 20'h00080, 16'h2222);
        add_row("char_rd", 24'h010100, 1'b1, 16'h0000, 8'h20, 1'b0, CS_CHR, 20'h08080, 16'h4444);
        add_row("pal_rd", 24'h000100, 1'b1, 16'h0000, 8'h40, 1'b0, CS_PAL, 20'h00080, 16'h5555);
        add_row("io_rd", 24'h000100, 1'b1, 16'h0000, 8'h80, 1'b0, CS_IO, 20'h00080, 16'hffff);
        add_row("rom_r0_5874", 24'h1c0000, 1'b1, 16'h0000, 8'h01, 1'b0, CS_ROM, 20'h20000, 16'h3333);
        add_row("rom_r1_5874", 24'h000100, 1'b1, 16'h0000, 8'h02, 1'b0, CS_ROM, 20'h00080, 16'h3333);
        add_row("vdp_r2", 24'h000100, 1'b1, 16'h0000, 8'h04, 1'b0, CS_VDP, 20'h00080, 16'h7777);
        add_row("r1_wr_5874", 24'h000100, 1'b0, 16'h0000, 8'h02, 1'b0, 9'h000, 20'h00080, 16'hffff);
        add_row("none_map", 24'h000100, 1'b1, 16'h0000, 8'h00, 1'b1, 9'h000, 20'h00080, 16'ha5a5);
        add_row("none_open", 24'h000100, 1'b1, 16'h0000, 8'h00, 1'b0, 9'h000, 20'h00080, 16'hffff);
        prio_now = 3'd5;
        add_row("prio_wr", 24'h002000, 1'b0, 16'h0005, 8'h80, 1'b0, CS_IO, 20'h01000, 16'hffff);
        add_row("io_wr_other", 24'h003000, 1'b0, 16'h0002, 8'h80, 1'b0, CS_IO, 20'h01800, 16'hffff);
        game_now = 8'h08;
        add_row("rom_r0_7525", 24'h1c0000, 1'b1, 16'h0000, 8'h01, 1'b0, CS_ROM, 20'h60000, 16'h3333);
        add_row("bank_7525", 24'h200000, 1'b0, 16'h0000, 8'h02, 1'b0, CS_BANK, 20'h40000, 16'hffff);
        game_now = 8'h10;
        add_row("rom_r1_5873", 24'h3c0000, 1'b1, 16'h0000, 8'h02, 1'b0, CS_ROM, 20'h60000, 16'h3333);
        game_now = 8'h02;
        add_row("rom_r1_dbr", 24'h1c0000, 1'b1, 16'h0000, 8'h02, 1'b0, CS_ROM, 20'h60000, 16'h3333);
        add_row("bank_dbr", 24'h200000, 1'b0, 16'h0000, 8'h02, 1'b0, CS_BANK, 20'h80000, 16'hffff);
        game_now = 8'h04;
        add_row("bank_5987", 24'h000100, 1'b0, 16'h0000, 8'h02, 1'b0, CS_BANK, 20'h00080, 16'hffff);
        game_now = 8'h20;
        add_row("vdp_r1_7248", 24'h000100, 1'b1, 16'h0000, 8'h02, 1'b0, CS_VDP, 20'h00080, 16'h7777);
        add_row("rom_r0_7248", 24'h1c0000, 1'b1, 16'h0000, 8'h01, 1'b0, CS_ROM, 20'h20000, 16'h3333);
        // X of 100 scales to 0x57 and 300 to 0xf6
        game_now = 8'h01;
        gun_now.p1_x = 9'd100;
        add_row("gun_ld_x100", 24'h003012, 1'b0, 16'h0000, 8'h80, 1'b0, CS_IO, 20'h01809, 16'hff7f);
        add_gun_reads(8'h57, 8);
        gun_now.p1_x = 9'd300;
        add_row("gun_ld_x300", 24'h003012, 1'b0, 16'h0000, 8'h80, 1'b0, CS_IO, 20'h01809, 16'hffff);
        add_gun_reads(8'hf6, 8);
        // Y of 0xa5 reads back inverted as 0x5a
        gun_now.p1_y = 9'h0a5;
        add_row("gun_ld_y", 24'h003010, 1'b0, 16'h0000, 8'h80, 1'b0, CS_IO, 20'h01808, 16'hff7f);
        add_gun_reads(8'h5a, 8);
        limit = rows.size() * 6 + 50;

        repeat (4) @(posedge clk);
        #1 rst = 1'b0;
        foreach (rows[i]) begin
            cur = rows[i];
            bus = cur.bus;
            active = cur.active;
            game_id = cur.game;
            none = cur.none;
            gun = cur.gun;
            repeat (3) @(posedge clk);
            #1 check = 1'b1;
            @(posedge clk);
            #1 check = 1'b0;
            release_bus();
            repeat (2) @(posedge clk);
            #1;
        end
        $display("%0d tests: %0d passed, %0d failed, %0d assertion failures", rows.size(),
                 pass_cnt, fail_cnt, UUT.u_decode.u_assertions.err_cnt);
        if (fail_cnt == 0 && pass_cnt == rows.size()
                && UUT.u_decode.u_assertions.err_cnt == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    initial begin
        cycles = 0;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (limit > 0 && cycles >= limit) begin
            $display("Timed out after %0d cycles before all tests finished", cycles);
            $display("sim failed");
            $finish;
        end
    end

endmodule

// File: s18_bus.f
+incdir+design
design/s18_pkg.sv
design/s18_region_decode.sv
design/s18_gun_adc.sv
design/s18_io_area.sv
design/s18_read_mux.sv
design/s18_main_bus.sv
verification/s18_assertions.sv
verification/s18_checker.sv
verification/s18_tb.sv

// File: Makefile
.PHONY: compile run clean

compile:
	verilator --binary --timing --assert --top-module s18_tb -f s18_bus.f -o s18_sim

run: compile
	./obj_dir/s18_sim | tee sim.log
	grep -q "sim passed" sim.log

clean:
	rm -rf obj_dir sim.log
